/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/axil_if.sv
      - rtl/lsu_align.sv
      - rtl/lsu_ctrl.sv
      - rtl/sram_axil.sv
      - rtl/lsu_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/lsu_props.sv
      - tb/tb_lsu.sv

/* rtl/axil_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axil_if;
    import lsu_pkg::*;

    addr_t araddr;
    logic  arvalid;
    logic  arready;

    word_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;

    addr_t awaddr;
    logic  awvalid;
    logic  awready;

    word_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;

    resp_t bresp;
    logic  bvalid;
    logic  bready;

    modport master (
        output araddr, arvalid, input arready,
        input rdata, rresp, rvalid, output rready,
        output awaddr, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready
    );

    modport slave (
        input araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready,
        input awaddr, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready
    );

endinterface

`default_nettype wire

/* rtl/lsu_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  lsu_pkg::size_t size,
    input  lsu_pkg::lane_t lane,
    input  logic           sign,
    input  lsu_pkg::word_t wdata,
    input  lsu_pkg::word_t mem_rdata,
    output lsu_pkg::word_t wmem,
    output lsu_pkg::strb_t wstrb,
    output lsu_pkg::word_t rdata_ext
);
    import lsu_pkg::*;

    logic [4:0] shamt;
    word_t      rshift;

    // byte offset to bit offset
    assign shamt = {lane, 3'b000};

    // store data moved into its byte lanes
    assign wmem = wdata << shamt;

    always_comb begin
        case (size)
            SZ_BYTE: wstrb = strb_t'(4'b0001 << lane);
            // halfword picks the low or high pair
            SZ_HALF: wstrb = lane[1] ? 4'b1100 : 4'b0011;
            SZ_WORD: wstrb = 4'b1111;
            default: wstrb = 4'b0000;
        endcase
    end

    // addressed bytes down to bit 0
    assign rshift = mem_rdata >> shamt;

    always_comb begin
        case (size)
            SZ_BYTE: rdata_ext = {{24{rshift[7] & sign}}, rshift[7:0]};
            SZ_HALF: rdata_ext = {{16{rshift[15] & sign}}, rshift[15:0]};
            SZ_WORD: rdata_ext = rshift;
            default: rdata_ext = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/lsu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    input  logic           we,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::word_t wmem,
    input  lsu_pkg::strb_t wstrb,
    output lsu_pkg::lane_t lane,
    output lsu_pkg::word_t mem_rdata,
    output logic           done,
    output logic           err,
    axil_if.master         bus
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        FINISH
    } state_t;

    state_t state;
    addr_t  addr_q;
    lane_t  lane_q;
    word_t  wmem_q;
    strb_t  wstrb_q;
    logic   start;

    assign start = req && (state == IDLE);

    // live lane in the request cycle so the store data lines up
    assign lane = req ? addr[1:0] : lane_q;

    // request capture
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            lane_q  <= addr[1:0];
            wmem_q  <= wmem;
            wstrb_q <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            err   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= we ? WR_ADDR : RD_ADDR;
                        err   <= 1'b0;
                    end
                end
                RD_ADDR: if (bus.arready) state <= RD_DATA;
                RD_DATA: begin
                    if (bus.rvalid) begin
                        state <= FINISH;
                        err   <= (bus.rresp != RESP_OKAY);
                    end
                end
                WR_ADDR: if (bus.awready) state <= WR_DATA;
                WR_DATA: if (bus.wready) state <= WR_RESP;
                WR_RESP: begin
                    if (bus.bvalid) begin
                        state <= FINISH;
                        err   <= (bus.bresp != RESP_OKAY);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read word is zero when the slave flags an error
    always_ff @(posedge clk) begin
        if (state == RD_DATA && bus.rvalid) begin
            mem_rdata <= (bus.rresp == RESP_OKAY) ? bus.rdata : '0;
        end
    end

    assign done = (state == FINISH);

    assign bus.araddr  = addr_q;
    assign bus.arvalid = (state == RD_ADDR);
    assign bus.rready  = (state == RD_DATA);
    assign bus.awaddr  = addr_q;
    assign bus.awvalid = (state == WR_ADDR);
    assign bus.wdata   = wmem_q;
    assign bus.wstrb   = wstrb_q;
    assign bus.wvalid  = (state == WR_DATA);
    assign bus.bready  = (state == WR_RESP);

endmodule

`default_nettype wire

/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  lane_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // code 0 means no access
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd1,
        SZ_HALF = 2'd2,
        SZ_WORD = 2'd3
    } size_t;

    // sram geometry with 4 bytes per word
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // wait state generator start value
    localparam logic [7:0] LFSR_SEED = 8'hb5;

endpackage

`default_nettype wire

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    input  logic           we,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::word_t wdata,
    output lsu_pkg::word_t rdata,
    output logic           done,
    output logic           err
);
    import lsu_pkg::*;

    lane_t lane;
    word_t wmem;
    strb_t wstrb;
    word_t mem_rdata;

    axil_if bus ();

    // size and sign held by the core until done
    lsu_align i_lsu_align (
        .size      (size),
        .lane      (lane),
        .sign      (sign),
        .wdata     (wdata),
        .mem_rdata (mem_rdata),
        .wmem      (wmem),
        .wstrb     (wstrb),
        .rdata_ext (rdata)
    );

    lsu_ctrl i_lsu_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wmem      (wmem),
        .wstrb     (wstrb),
        .lane      (lane),
        .mem_rdata (mem_rdata),
        .done      (done),
        .err       (err),
        .bus       (bus.master)
    );

    sram_axil i_sram_axil (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.slave)
    );

endmodule

`default_nettype wire

/* rtl/sram_axil.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axil (
    input  logic  clk,
    input  logic  rst_n,
    axil_if.slave bus
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_WDATA,
        SL_BWAIT,
        SL_BRESP,
        SL_RWAIT,
        SL_RRESP
    } sl_state_t;

    sl_state_t  state;
    logic [7:0] lfsr;
    logic [1:0] wait_cnt;
    logic       wait_done;
    logic       ar_fire;
    logic       aw_fire;
    logic       w_fire;
    word_t      mem [MEM_WORDS];
    addr_t      wr_addr;
    word_t      rd_data;
    resp_t      rd_resp;
    resp_t      wr_resp;

    function automatic logic in_range(addr_t a);
        return a[31:MEM_AW+2] == '0;
    endfunction

    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign wait_done   = (wait_cnt == 2'd0);
    assign bus.arready = (state == SL_IDLE) && bus.arvalid && wait_done;
    assign bus.awready = (state == SL_IDLE) && bus.awvalid && !bus.arvalid && wait_done;
    assign bus.wready  = (state == SL_WDATA) && bus.wvalid && wait_done;
    assign bus.rvalid  = (state == SL_RRESP);
    assign bus.bvalid  = (state == SL_BRESP);
    assign bus.rdata   = rd_data;
    assign bus.rresp   = rd_resp;
    assign bus.bresp   = wr_resp;

    assign ar_fire = bus.arvalid && bus.arready;
    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;

    // wait counter reloads from the lfsr ahead of each ready and response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SL_IDLE;
            wait_cnt <= 2'd0;
        end else begin
            case (state)
                SL_IDLE: begin
                    if (ar_fire) begin
                        state    <= SL_RWAIT;
                        wait_cnt <= lfsr[1:0];
                    end else if (aw_fire) begin
                        state    <= SL_WDATA;
                        wait_cnt <= lfsr[1:0];
                    end else if (bus.arvalid || bus.awvalid) begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end else begin
                        wait_cnt <= lfsr[1:0];
                    end
                end
                SL_WDATA: begin
                    if (w_fire) begin
                        state    <= SL_BWAIT;
                        wait_cnt <= lfsr[1:0];
                    end else if (bus.wvalid) begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                SL_BWAIT: begin
                    if (wait_done) state <= SL_BRESP;
                    else wait_cnt <= wait_cnt - 2'd1;
                end
                SL_BRESP: begin
                    if (bus.bready) begin
                        state    <= SL_IDLE;
                        wait_cnt <= lfsr[1:0];
                    end
                end
                SL_RWAIT: begin
                    if (wait_done) state <= SL_RRESP;
                    else wait_cnt <= wait_cnt - 2'd1;
                end
                SL_RRESP: begin
                    if (bus.rready) begin
                        state    <= SL_IDLE;
                        wait_cnt <= lfsr[1:0];
                    end
                end
                default: state <= SL_IDLE;
            endcase
        end
    end

    // read data sampled at the address transfer
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            if (in_range(bus.araddr)) begin
                rd_data <= mem[bus.araddr[MEM_AW+1:2]];
                rd_resp <= RESP_OKAY;
            end else begin
                rd_data <= '0;
                rd_resp <= RESP_SLVERR;
            end
        end
    end

    // byte lane merge on the data transfer
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr <= bus.awaddr;
        end
        if (w_fire) begin
            if (in_range(wr_addr)) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.wstrb[i]) begin
                        mem[wr_addr[MEM_AW+1:2]][8*i +: 8] <= bus.wdata[8*i +: 8];
                    end
                end
                wr_resp <= RESP_OKAY;
            end else begin
                wr_resp <= RESP_SLVERR;
            end
        end
    end

endmodule

`default_nettype wire

/* src.f */
rtl/lsu_pkg.sv
rtl/axil_if.sv
rtl/lsu_align.sv
rtl/lsu_ctrl.sv
rtl/sram_axil.sv
rtl/lsu_top.sv
tb/tb_clkgen.sv
tb/lsu_props.sv
tb/tb_lsu.sv

/* tb/lsu_patterns.txt */
# columns, all hex: we size sign addr wdata expected_rdata expected_err
# size 1 byte, 2 halfword, 3 word; expected_rdata is ignored for writes
1 3 0 00000000 12345678 00000000 0
0 3 0 00000000 00000000 12345678 0
1 3 0 00000004 aabbccdd 00000000 0
1 1 0 00000004 ffffff11 00000000 0
0 3 0 00000004 00000000 aabbcc11 0
1 1 0 00000005 deadbe22 00000000 0
1 1 0 00000006 00000033 00000000 0
1 1 0 00000007 00000044 00000000 0
0 3 0 00000004 00000000 44332211 0
1 3 0 00000008 807f01fe 00000000 0
0 1 1 00000008 00000000 fffffffe 0
0 1 0 00000008 00000000 000000fe 0
0 1 1 00000009 00000000 00000001 0
0 1 1 0000000a 00000000 0000007f 0
0 1 1 0000000b 00000000 ffffff80 0
0 1 0 0000000b 00000000 00000080 0
0 2 1 00000008 00000000 000001fe 0
0 2 1 0000000a 00000000 ffff807f 0
0 2 0 0000000a 00000000 0000807f 0
1 3 0 0000000c 017f80ff 00000000 0
0 1 1 0000000d 00000000 ffffff80 0
0 2 1 0000000c 00000000 ffff80ff 0
0 2 0 0000000c 00000000 000080ff 0
0 2 1 0000000e 00000000 0000017f 0
0 1 1 00000004 00000000 00000011 0
1 2 0 0000000e 0000beef 00000000 0
0 3 0 0000000c 00000000 beef80ff 0
1 3 0 00000400 cafef00d 00000000 1
0 3 0 00000400 00000000 00000000 1
0 3 0 00000000 00000000 12345678 0
0 1 1 00001003 00000000 00000000 1

/* tb/lsu_props.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_props (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic done,
    input logic arvalid,
    input logic arready,
    input logic rvalid,
    input logic rready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic bready
);

    // open from req up to and including the done cycle
    logic busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (req) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    property valid_held(logic valid, logic ready);
        @(posedge clk) disable iff (!rst_n) valid && !ready |=> valid;
    endproperty

    ar_held: assert property (valid_held(arvalid, arready)) else $error("arvalid dropped early");
    aw_held: assert property (valid_held(awvalid, awready)) else $error("awvalid dropped early");
    w_held:  assert property (valid_held(wvalid, wready)) else $error("wvalid dropped early");
    r_held:  assert property (valid_held(rvalid, rready)) else $error("rvalid dropped early");
    b_held:  assert property (valid_held(bvalid, bready)) else $error("bvalid dropped early");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done high for more than one cycle");

    req_idle: assert property (@(posedge clk) disable iff (!rst_n) req |-> !busy)
        else $error("req while an access is still open");

endmodule

bind lsu_ctrl lsu_props i_lsu_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .done    (done),
    .arvalid (bus.arvalid),
    .arready (bus.arready),
    .rvalid  (bus.rvalid),
    .rready  (bus.rready),
    .awvalid (bus.awvalid),
    .awready (bus.awready),
    .wvalid  (bus.wvalid),
    .wready  (bus.wready),
    .bvalid  (bus.bvalid),
    .bready  (bus.bready)
);

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk
);

    // 20 ns period
    localparam time HALF_PERIOD = 10ns;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

/* tb/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    localparam int    RESET_CYCLES = 4;
    localparam int    DONE_TIMEOUT = 40;
    localparam string PATTERN_FILE = "tb/lsu_patterns.txt";

    logic  clk;
    logic  rst_n;
    logic  req;
    logic  we;
    logic  sign;
    size_t size;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic  done;
    logic  err;

    integer seed;
    int     error_count;
    int     access_count;

    tb_clkgen i_tb_clkgen (
        .clk (clk)
    );

    lsu_top i_lsu_top (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .we    (we),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err)
    );

    task automatic stop_on_error();
        error_count++;
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0d ns %s: got %08h, expected %08h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // one access that starts and ends on a falling edge
    task automatic run_access(
        input logic  op_we,
        input size_t op_size,
        input logic  op_sign,
        input addr_t op_addr,
        input word_t op_wdata,
        input word_t exp_rdata,
        input logic  exp_err
    );
        int cycles;
        we    = op_we;
        size  = op_size;
        sign  = op_sign;
        addr  = op_addr;
        wdata = op_wdata;
        req   = 1'b1;
        @(negedge clk);
        req    = 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (done) else begin
            $display("Timeout: access %0d at address %08h got no done within %0d cycles",
                     access_count, op_addr, DONE_TIMEOUT);
            stop_on_error();
        end
        // size and sign are still held so rdata is the extended load value
        compare_value("err", word_t'(err), word_t'(exp_err));
        if (!op_we) begin
            compare_value("rdata", rdata, exp_rdata);
        end
        access_count++;
    endtask

    initial begin
        int          fd;
        int          fields;
        int          gap;
        string       line;
        logic [31:0] f_we;
        logic [31:0] f_size;
        logic [31:0] f_sign;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_err;

        seed         = 32'h40d8_29fe;
        error_count  = 0;
        access_count = 0;
        rst_n        = 1'b0;
        req          = 1'b0;
        we           = 1'b0;
        sign         = 1'b0;
        size         = SZ_WORD;
        addr         = '0;
        wdata        = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        fd = $fopen(PATTERN_FILE, "r");
        assert (fd != 0) else begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            stop_on_error();
        end

        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (fields > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h",
                                 f_we, f_size, f_sign, f_addr, f_wdata, f_rdata, f_err);
                if (fields == 7) begin
                    run_access(f_we[0], size_t'(f_size[1:0]), f_sign[0], f_addr,
                               f_wdata, f_rdata, f_err[0]);
                    // idle gap of 0 to 3 cycles before the next request
                    gap = $unsigned($random(seed)) % 4;
                    repeat (gap + 1) @(negedge clk);
                end else if (fields > 0) begin
                    $display("Malformed line in %s: %s", PATTERN_FILE, line);
                    stop_on_error();
                end
            end
        end
        $fclose(fd);

        assert (access_count > 0) else begin
            $display("No accesses were read from %s", PATTERN_FILE);
            stop_on_error();
        end

        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
